/* build.f */
source/bus_pkg.sv
source/spi_frame_pkg.sv
source/spi_wb_bridge.sv
source/wb_addr_decode.sv
source/led_pwm_channel.sv
source/wb_read_merge.sv
source/spi_led_top.sv
test/spi_led_properties.sv
test/tb_spi_led.sv

/* test/tb_spi_led.sv */
module tb_spi_led;
  timeunit 1ns;
  timeprecision 1ps;
  import bus_pkg::*;
  import spi_frame_pkg::*;

  localparam int ClkPeriod = 8;
  localparam int HalfPeriod = 10;
  localparam int PwmPeriod = 2 ** PwmWidth;
  localparam int NumUnmapped = 8;
  localparam int NumRandom = 40;
  // setup half, 32 sck halves, hold half, two halves of gap
  localparam int FrameCycles = (2 * FrameBits + 4) * HalfPeriod;
  localparam int NumFrames = 4 * NumChannels + 1 + NumUnmapped + 3 + NumRandom;
  localparam int PwmWindows = 2;
  localparam int TimeoutNs = (NumFrames * FrameCycles + PwmWindows * (PwmPeriod + 4) +
                              1000) * ClkPeriod;

  logic clk_i;
  logic rst_n;
  logic spi_sck;
  logic spi_csn;
  logic spi_sdi;
  logic spi_sdo;
  logic [NumChannels-1:0] rgb;

  // reference duties
  bus_dat_t model_duty [NumChannels];
  int high_cnt [NumChannels];
  int err_cnt;
  int err_mark;
  int tests_run;
  int tests_ok;

  spi_led_top u_dut (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .spi_sck (spi_sck),
    .spi_csn (spi_csn),
    .spi_sdi (spi_sdi),
    .spi_sdo (spi_sdo),
    .rgb     (rgb)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // lands 1 ns after the nth rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // mode 0, msb first, sdo taken on rising sck
  // n_bits below FrameBits aborts the frame
  task automatic spi_frame(input bus_dat_t cmd, input bus_dat_t dat, input int n_bits,
                           output bus_dat_t rd);
    logic [FrameBits-1:0] tx;
    tx = {cmd, dat};
    rd = '0;
    spi_csn = 1'b0;
    wait_cycles(HalfPeriod);
    for (int i = 0; i < n_bits; i++) begin
      spi_sdi = tx[FrameBits-1-i];
      wait_cycles(HalfPeriod);
      spi_sck = 1'b1;
      if (i >= BitsPerByte) begin
        rd = {rd[BitsPerByte-2:0], spi_sdo};
      end
      wait_cycles(HalfPeriod);
      spi_sck = 1'b0;
    end
    wait_cycles(HalfPeriod);
    spi_csn = 1'b1;
    spi_sdi = 1'b0;
    wait_cycles(2 * HalfPeriod);
  endtask

  task automatic write_reg(input bus_adr_t adr, input bus_dat_t dat);
    bus_dat_t unused;
    spi_frame({1'b1, 3'b000, adr}, dat, FrameBits, unused);
    // only channel addresses hold state
    if (int'(adr) < NumChannels) begin
      model_duty[adr] = dat;
    end
  endtask

  task automatic read_reg(input bus_adr_t adr, output bus_dat_t rd);
    spi_frame({1'b0, 3'b000, adr}, '0, FrameBits, rd);
  endtask

  // id byte, duty, or zero for unmapped
  function automatic bus_dat_t expected_read(input bus_adr_t adr);
    if (adr == IdAddr) begin
      return IdValue;
    end else if (int'(adr) < NumChannels) begin
      return model_duty[adr];
    end
    return '0;
  endfunction

  task automatic check_dat(input bus_adr_t adr, input bus_dat_t got, input bus_dat_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error: spi_sdo read at adr 0x%h got 0x%02h expected 0x%02h", adr, got, exp);
    end
  endtask

  task automatic check_led_count(input int ch, input int got, input bus_dat_t duty);
    if (got != int'(duty)) begin
      err_cnt++;
      $display("Error: rgb[%0d] high cycles got 0x%0h expected 0x%0h", ch, got, duty);
    end
  endtask

  // high cycles of every channel over one pwm period
  task automatic count_high();
    for (int c = 0; c < NumChannels; c++) begin
      high_cnt[c] = 0;
    end
    repeat (PwmPeriod) begin
      wait_cycles(1);
      for (int c = 0; c < NumChannels; c++) begin
        if (rgb[c]) begin
          high_cnt[c] = high_cnt[c] + 1;
        end
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == err_mark) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // watchdog
  initial begin
    #(TimeoutNs);
    $display("watchdog expired before the tests completed");
    $display("sim failed");
    $finish;
  end

  initial begin
    bus_dat_t rd;
    bus_dat_t val;
    bus_adr_t adr;
    clk_i = 1'b0;
    rst_n = 1'b1;
    spi_sck = 1'b0;
    spi_csn = 1'b1;
    spi_sdi = 1'b0;
    err_cnt = 0;
    err_mark = 0;
    tests_run = 0;
    tests_ok = 0;
    for (int c = 0; c < NumChannels; c++) begin
      model_duty[c] = '0;
    end
    void'($urandom(32'he32544b9));
    // clean falling edge into reset
    #1 rst_n = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 rst_n = 1'b1;
    wait_cycles(4);

    // random duty readback
    for (int c = 0; c < NumChannels; c++) begin
      write_reg(bus_adr_t'(c), bus_dat_t'($urandom));
    end
    for (int c = 0; c < NumChannels; c++) begin
      read_reg(bus_adr_t'(c), rd);
      check_dat(bus_adr_t'(c), rd, expected_read(bus_adr_t'(c)));
    end
    end_test("duty readback");

    read_reg(IdAddr, rd);
    check_dat(IdAddr, rd, expected_read(IdAddr));
    end_test("id register");

    // unmapped space between channels and id
    for (int i = 0; i < NumUnmapped; i++) begin
      adr = bus_adr_t'(NumChannels + ($urandom % (int'(IdAddr) - NumChannels)));
      read_reg(adr, rd);
      check_dat(adr, rd, expected_read(adr));
      if (u_dut.bus_stb !== 1'b0) begin
        err_cnt++;
        $display("bus strobe still high after a read of unmapped address 0x%h", adr);
      end
    end
    end_test("unmapped reads");

    // first round hits both extremes
    for (int r = 0; r < PwmWindows; r++) begin
      for (int c = 0; c < NumChannels; c++) begin
        if (r == 0 && c == 0) begin
          val = 8'h00;
        end else if (r == 0 && c == 1) begin
          val = 8'hFF;
        end else begin
          val = bus_dat_t'($urandom);
        end
        write_reg(bus_adr_t'(c), val);
      end
      wait_cycles(4);
      count_high();
      for (int c = 0; c < NumChannels; c++) begin
        check_led_count(c, high_cnt[c], model_duty[c]);
      end
    end
    end_test("pwm high count");

    // write cut off after 12 bits
    adr = bus_adr_t'($urandom % NumChannels);
    write_reg(adr, bus_dat_t'($urandom));
    spi_frame({1'b1, 3'b000, adr}, ~model_duty[adr], 12, rd);
    read_reg(adr, rd);
    check_dat(adr, rd, expected_read(adr));
    end_test("aborted frame");

    // mixed traffic over the whole address space
    for (int i = 0; i < NumRandom; i++) begin
      adr = bus_adr_t'($urandom);
      if ($urandom % 2) begin
        write_reg(adr, bus_dat_t'($urandom));
      end else begin
        read_reg(adr, rd);
        check_dat(adr, rd, expected_read(adr));
      end
    end
    end_test("random traffic");

    $display("tests run %0d, passed %0d, check errors %0d", tests_run, tests_ok, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* test/spi_led_properties.sv */
module spi_led_properties (
  input logic                            clk_i,
  input logic                            rst_n,
  input logic                            bus_stb,
  input logic                            bus_we,
  input bus_pkg::bus_adr_t               bus_adr,
  input bus_pkg::bus_dat_t               bus_wdat,
  input logic                            bus_ack,
  input logic [bus_pkg::NumChannels-1:0] chan_ack,
  input logic                            dec_ack,
  input logic [bus_pkg::NumChannels-1:0] rgb
);
  timeunit 1ns;
  timeprecision 1ps;

  // request held until the ack is seen
  // write data only matters on writes
  a_stb_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    bus_stb && !bus_ack |=> bus_stb && $stable(bus_adr) && $stable(bus_we) &&
                            (!bus_we || $stable(bus_wdat))
  ) else $error("bus request changed or dropped before ack");

  // ack never without a strobe
  a_ack_in_stb: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    bus_ack |-> bus_stb
  ) else $error("bus ack seen while strobe was low");

  // every access answered by exactly one responder
  // a channel for its own address, the decoder for id and unmapped
  a_one_responder: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    $rose(bus_stb) |=> $onehot({chan_ack, dec_ack})
  ) else $error("bus access not answered by exactly one responder");

  // leds dark while in reset
  a_rgb_reset: assert property (
    @(posedge clk_i) !rst_n |-> rgb == '0
  ) else $error("rgb not zero during reset");

endmodule

bind spi_led_top spi_led_properties u_props (.*);

/* source/spi_led_top.sv */
module spi_led_top (
  input  logic                            clk_i,
  input  logic                            rst_n,
  input  logic                            spi_sck,
  input  logic                            spi_csn,
  input  logic                            spi_sdi,
  output logic                            spi_sdo,
  output logic [bus_pkg::NumChannels-1:0] rgb
);
  import bus_pkg::*;

  // bridge side of the bus
  logic     bus_stb;
  logic     bus_we;
  bus_adr_t bus_adr;
  bus_dat_t bus_wdat;
  logic     bus_ack;
  bus_dat_t bus_rdat;

  // per channel strobes and responses
  logic [NumChannels-1:0]     chan_stb;
  logic [NumChannels-1:0]     chan_ack;
  bus_dat_t [NumChannels-1:0] chan_rdat;

  // decoder's own response
  logic     dec_ack;
  bus_dat_t dec_rdat;

  spi_wb_bridge u_bridge (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .spi_sck  (spi_sck),
    .spi_csn  (spi_csn),
    .spi_sdi  (spi_sdi),
    .spi_sdo  (spi_sdo),
    .bus_stb  (bus_stb),
    .bus_we   (bus_we),
    .bus_adr  (bus_adr),
    .bus_wdat (bus_wdat),
    .bus_ack  (bus_ack),
    .bus_rdat (bus_rdat)
  );

  wb_addr_decode u_decode (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .bus_stb  (bus_stb),
    .bus_adr  (bus_adr),
    .chan_stb (chan_stb),
    .dec_ack  (dec_ack),
    .dec_rdat (dec_rdat)
  );

  // one channel per colour, write data shared
  for (genvar i = 0; i < NumChannels; i++) begin : g_chan
    led_pwm_channel u_chan (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .chan_stb  (chan_stb[i]),
      .bus_we    (bus_we),
      .bus_wdat  (bus_wdat),
      .chan_ack  (chan_ack[i]),
      .chan_rdat (chan_rdat[i]),
      .led       (rgb[i])
    );
  end

  wb_read_merge u_merge (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .chan_ack  (chan_ack),
    .chan_rdat (chan_rdat),
    .dec_ack   (dec_ack),
    .dec_rdat  (dec_rdat),
    .bus_ack   (bus_ack),
    .bus_rdat  (bus_rdat)
  );

endmodule

/* source/wb_read_merge.sv */
module wb_read_merge (
  input  logic                                             clk_i,
  input  logic                                             rst_n,
  input  logic              [bus_pkg::NumChannels-1:0]      chan_ack,
  input  bus_pkg::bus_dat_t [bus_pkg::NumChannels-1:0]      chan_rdat,
  input  logic                                             dec_ack,
  input  bus_pkg::bus_dat_t                                dec_rdat,
  output logic                                             bus_ack,
  output bus_pkg::bus_dat_t                                bus_rdat
);
  import bus_pkg::*;

  logic any_ack;
  bus_dat_t sel_dat;

  // and-or select
  // at most one responder acks, zero when nobody does
  always_comb begin
    any_ack = dec_ack | (|chan_ack);
    sel_dat = dec_ack ? dec_rdat : '0;
    for (int i = 0; i < NumChannels; i++) begin
      if (chan_ack[i]) begin
        sel_dat = sel_dat | chan_rdat[i];
      end
    end
  end

  // one register stage back to the bridge
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= any_ack;
    end
  end

  // read data travels with the ack
  always_ff @(posedge clk_i) begin
    bus_rdat <= sel_dat;
  end

endmodule

/* source/led_pwm_channel.sv */
module led_pwm_channel (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              chan_stb,
  input  logic              bus_we,
  input  bus_pkg::bus_dat_t bus_wdat,
  output logic              chan_ack,
  output bus_pkg::bus_dat_t chan_rdat,
  output logic              led
);
  import bus_pkg::*;

  // strobe level one cycle ago
  logic stb_q;
  logic new_acc;

  bus_dat_t duty;
  logic [PwmWidth-1:0] pwm_cnt;

  // only the first strobe cycle counts
  assign new_acc = chan_stb & ~stb_q;

  // bus port
  // write on the first strobe cycle, ack one cycle later
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      stb_q    <= 1'b0;
      chan_ack <= 1'b0;
      duty     <= '0;
    end else begin
      stb_q    <= chan_stb;
      chan_ack <= new_acc;
      if (new_acc && bus_we) begin
        duty <= bus_wdat;
      end
    end
  end

  // readback of the duty register
  assign chan_rdat = duty;

  // pwm generator
  // wraps every 2**PwmWidth cycles
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  // high while the counter is below duty
  // duty cycles high per period, zero stays dark
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      led <= 1'b0;
    end else begin
      led <= (pwm_cnt < duty);
    end
  end

endmodule

/* source/wb_addr_decode.sv */
module wb_addr_decode (
  input  logic                           clk_i,
  input  logic                           rst_n,
  input  logic                           bus_stb,
  input  bus_pkg::bus_adr_t              bus_adr,
  output logic [bus_pkg::NumChannels-1:0] chan_stb,
  output logic                           dec_ack,
  output bus_pkg::bus_dat_t              dec_rdat
);
  import bus_pkg::*;

  // strobe level one cycle ago
  logic stb_q;
  logic new_acc;
  logic mapped;

  // first cycle of an access
  assign new_acc = bus_stb & ~stb_q;

  // channel addresses start at zero
  assign mapped = bus_adr < bus_adr_t'(NumChannels);

  // strobe fan-out, one channel per address
  always_comb begin
    for (int i = 0; i < NumChannels; i++) begin
      chan_stb[i] = bus_stb && (bus_adr == bus_adr_t'(i));
    end
  end

  // ack for id and unmapped addresses
  // a single ack per strobe
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      stb_q   <= 1'b0;
      dec_ack <= 1'b0;
    end else begin
      stb_q   <= bus_stb;
      dec_ack <= new_acc & ~mapped;
    end
  end

  // id byte or zero
  always_ff @(posedge clk_i) begin
    if (new_acc) begin
      dec_rdat <= (bus_adr == IdAddr) ? IdValue : '0;
    end
  end

endmodule

/* source/spi_wb_bridge.sv */
module spi_wb_bridge (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              spi_sck,
  input  logic              spi_csn,
  input  logic              spi_sdi,
  output logic              spi_sdo,
  output logic              bus_stb,
  output logic              bus_we,
  output bus_pkg::bus_adr_t bus_adr,
  output bus_pkg::bus_dat_t bus_wdat,
  input  logic              bus_ack,
  input  bus_pkg::bus_dat_t bus_rdat
);
  import bus_pkg::*;
  import spi_frame_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_cmd,
    st_rd_acc,
    st_data,
    st_wr_acc
  } state_t;

  state_t state;

  // two sync stages, third stage of sck keeps the previous level
  logic [2:0] sck_sync;
  logic [1:0] csn_sync;
  logic [1:0] sdi_sync;

  logic sck_s;
  logic sck_d;
  logic csn_s;
  logic sdi_s;
  logic sck_rise;
  logic sck_fall;

  spi_bit_cnt_t bit_cnt;
  logic [BitsPerByte-2:0] rx_shift;
  bus_dat_t rx_byte;
  bus_dat_t tx_shift;
  logic cmd_done;
  logic frame_done;

  // pin synchronizers
  // csn comes up inactive
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync <= '0;
      csn_sync <= '1;
      sdi_sync <= '0;
    end else begin
      sck_sync <= {sck_sync[1:0], spi_sck};
      csn_sync <= {csn_sync[0], spi_csn};
      sdi_sync <= {sdi_sync[0], spi_sdi};
    end
  end

  assign sck_s = sck_sync[1];
  assign sck_d = sck_sync[2];
  assign csn_s = csn_sync[1];
  assign sdi_s = sdi_sync[1];

  assign sck_rise = sck_s & ~sck_d;
  assign sck_fall = ~sck_s & sck_d;

  // byte as it stands once the current bit is in
  assign rx_byte = {rx_shift, sdi_s};

  // 8th and 16th rising edge of the frame
  assign cmd_done = sck_rise && !csn_s &&
                    (bit_cnt == spi_bit_cnt_t'(BitsPerByte - 1));
  assign frame_done = sck_rise && !csn_s &&
                      (bit_cnt == spi_bit_cnt_t'(FrameBits - 1));

  // bit counter, restarts whenever csn is high
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (csn_s) begin
      bit_cnt <= '0;
    end else if (sck_rise) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // receive shifter, msb first, sampled on rising sck
  always_ff @(posedge clk_i) begin
    if (sck_rise) begin
      rx_shift <= rx_byte[BitsPerByte-2:0];
    end
  end

  // access address and write data
  always_ff @(posedge clk_i) begin
    if (state == st_cmd && cmd_done) begin
      bus_adr <= bus_adr_t'(rx_byte);
    end
    if (state == st_data && frame_done) begin
      bus_wdat <= rx_byte;
    end
  end

  // frame sequencer
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      bus_stb <= 1'b0;
      bus_we  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (!csn_s) begin
            state <= st_cmd;
          end
        end
        st_cmd: begin
          if (csn_s) begin
            state <= st_idle;
          end else if (cmd_done) begin
            bus_we <= rx_byte[CmdWeBit];
            // reads go out now so the data is ready for the second byte
            if (rx_byte[CmdWeBit]) begin
              state <= st_data;
            end else begin
              bus_stb <= 1'b1;
              state   <= st_rd_acc;
            end
          end
        end
        st_rd_acc: begin
          // strobe must complete even if csn rises meanwhile
          if (bus_ack) begin
            bus_stb <= 1'b0;
            state   <= st_data;
          end
        end
        st_data: begin
          // aborted frame, no write
          if (csn_s) begin
            state <= st_idle;
          end else if (frame_done) begin
            if (bus_we) begin
              bus_stb <= 1'b1;
              state   <= st_wr_acc;
            end else begin
              state <= st_idle;
            end
          end
        end
        st_wr_acc: begin
          if (bus_ack) begin
            bus_stb <= 1'b0;
            state   <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // transmit shifter
  // loaded from the read ack, shifted out on falling sck in the data byte
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      spi_sdo  <= 1'b0;
      tx_shift <= '0;
    end else if (csn_s) begin
      spi_sdo <= 1'b0;
    end else if (state == st_rd_acc && bus_ack) begin
      tx_shift <= bus_rdat;
    end else if (state == st_cmd && cmd_done) begin
      // write frames send zeros back
      tx_shift <= '0;
    end else if (sck_fall) begin
      if (state == st_data) begin
        spi_sdo  <= tx_shift[BitsPerByte-1];
        tx_shift <= {tx_shift[BitsPerByte-2:0], 1'b0};
      end else begin
        spi_sdo <= 1'b0;
      end
    end
  end

endmodule

/* source/spi_frame_pkg.sv */
package spi_frame_pkg;

  // counts the bits of one frame
  // wraps to zero after the last bit
  typedef logic [3:0] spi_bit_cnt_t;

  // write select in the command byte
  localparam int CmdWeBit = 7;

  // command byte then data byte
  localparam int BitsPerByte = 8;
  localparam int FrameBits = 16;

endpackage

/* source/bus_pkg.sv */
package bus_pkg;

  // internal bus widths
  localparam int AdrWidth = 4;
  localparam int DatWidth = 8;

  // register address as carried by the command byte
  typedef logic [AdrWidth-1:0] bus_adr_t;

  // bus data and duty value
  typedef logic [DatWidth-1:0] bus_dat_t;

  // one pwm channel per colour
  // channels sit at addresses 0 .. NumChannels-1
  localparam int NumChannels = 3;

  // identification register
  localparam bus_adr_t IdAddr = 4'hF;
  localparam bus_dat_t IdValue = 8'hA5;

  // free-running pwm counter width
  // period is 2**PwmWidth clk_i cycles
  localparam int PwmWidth = 8;

endpackage
